// File: hw/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // --------------------------------------------------
    // bus timing
    // --------------------------------------------------
    localparam int QUARTER_CYCLES = 4;   // system clocks per quarter bit

    // --------------------------------------------------
    // serial eeprom addressing
    // --------------------------------------------------
    localparam logic [3:0] DEV_CODE = 4'b1010;  // family code, top of control byte
    localparam logic [2:0] DEV_SEL  = 3'b000;   // select bits this device answers to
    localparam int         MEM_DEPTH = 256;     // one address byte

    // --------------------------------------------------
    // wishbone register map, word indices
    // --------------------------------------------------
    localparam logic [1:0] REG_ADDR   = 2'd0;
    localparam logic [1:0] REG_DATA   = 2'd1;
    localparam logic [1:0] REG_CMD    = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd3;

    // command register fields
    localparam int CMD_GO_BIT   = 0;
    localparam int CMD_READ_BIT = 1;
    localparam int CMD_SEL_LSB  = 2;   // select occupies bits 4..2

    // status register fields
    localparam int ST_BUSY_BIT = 0;
    localparam int ST_NACK_BIT = 1;
    localparam int ST_DONE_BIT = 2;

endpackage

`default_nettype wire

// File: hw/wb_eeprom_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_eeprom_regs (
    input  logic       scl,
    input  logic       rst_n,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [1:0] wb_adr,
    input  logic [7:0] wb_dat_w,
    input  logic       txn_busy,
    input  logic       txn_end,
    input  logic [7:0] txn_rdata,
    input  logic       txn_nack,
    output logic [7:0] wb_dat_r,
    output logic       wb_ack,
    output logic       txn_start,
    output logic       txn_read,
    output logic [2:0] txn_sel,
    output logic [7:0] txn_addr,
    output logic [7:0] txn_wdata
);
    import eeprom_pkg::*;

    logic       req;
    logic       busy;
    logic       launch;
    logic       nack_q;
    logic       done_q;
    logic [7:0] status;
    logic [7:0] cmd_rd;

    assign req    = wb_cyc & wb_stb & ~wb_ack;   // first cycle of an access only
    assign busy   = txn_busy | txn_start;        // covers the gap before master busy
    assign launch = req & wb_we & (wb_adr == REG_CMD) & wb_dat_w[CMD_GO_BIT] & ~busy;

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_ack    <= 1'b0;
            txn_start <= 1'b0;
            txn_read  <= 1'b0;
            txn_sel   <= '0;
            txn_addr  <= '0;
            txn_wdata <= '0;
            nack_q    <= 1'b0;
            done_q    <= 1'b0;
        end
        else
        begin
            wb_ack    <= req;
            txn_start <= launch;
            if (req && wb_we && wb_adr == REG_ADDR)
                txn_addr <= wb_dat_w;
            if (req && wb_we && wb_adr == REG_DATA)
                txn_wdata <= wb_dat_w;
            if (launch)
            begin
                txn_read <= wb_dat_w[CMD_READ_BIT];
                txn_sel  <= wb_dat_w[CMD_SEL_LSB +: 3];
                done_q   <= 1'b0;
                nack_q   <= 1'b0;
            end
            if (txn_end)
            begin
                if (txn_read)
                    txn_wdata <= txn_rdata;   // read result lands in data reg
                nack_q <= txn_nack;
                done_q <= 1'b1;
            end
        end
    end

    always_comb
    begin
        status = '0;
        status[ST_BUSY_BIT] = busy;
        status[ST_NACK_BIT] = nack_q;
        status[ST_DONE_BIT] = done_q;
        cmd_rd = '0;                            // go reads back as zero
        cmd_rd[CMD_READ_BIT] = txn_read;
        cmd_rd[CMD_SEL_LSB +: 3] = txn_sel;
        case (wb_adr)
            REG_ADDR: wb_dat_r = txn_addr;
            REG_DATA: wb_dat_r = txn_wdata;
            REG_CMD:  wb_dat_r = cmd_rd;
            default:  wb_dat_r = status;
        endcase
    end

    // single-cycle ack per access
    a_ack_single: assert property (@(posedge scl) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

// File: hw/i2c_txn_master.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_txn_master (
    input  logic       scl,
    input  logic       rst_n,
    input  logic       txn_start,
    input  logic       txn_read,
    input  logic [2:0] txn_sel,
    input  logic [7:0] txn_addr,
    input  logic [7:0] txn_wdata,
    input  logic       bus_clk,
    input  logic       bus_dat,
    output logic       bus_clk_low,
    output logic       dat_low_m,
    output logic       txn_busy,
    output logic       txn_end,
    output logic [7:0] txn_rdata,
    output logic       txn_nack
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {P_IDLE, P_START, P_BYTE, P_ACK, P_STOP} phase_t;

    phase_t phase;
    phase_t nxt_phase;
    logic [$clog2(QUARTER_CYCLES)-1:0] qcnt;
    logic [1:0] q;          // quarter within the bit
    logic [2:0] bitcnt;
    logic [1:0] idx;        // byte number within the transaction
    logic [1:0] nxt_idx;
    logic       nack_q;
    logic       tick;
    logic       stall;
    logic       adv;
    logic       last;
    logic [7:0] shreg;
    logic       rd_q;
    logic [2:0] sel_q;
    logic [7:0] addr_q;
    logic [7:0] wdata_q;

    // byte sent for each slot, 0xff releases the line for read data
    function automatic logic [7:0] byte_for(input logic [1:0] n);
        logic [7:0] b;
        case (n)
            2'd0:    b = {DEV_CODE, sel_q, 1'b0};
            2'd1:    b = addr_q;
            2'd2:    b = rd_q ? {DEV_CODE, sel_q, 1'b1} : wdata_q;
            default: b = 8'hff;
        endcase
        return b;
    endfunction

    assign tick  = (qcnt == $bits(qcnt)'(QUARTER_CYCLES - 1));
    assign stall = (q == 2'd2) && !bus_clk;     // wait for the line to really rise
    assign adv   = (phase != P_IDLE) && tick && !stall;
    assign last  = rd_q ? (idx == 2'd3) : (idx == 2'd2);

    assign txn_busy  = (phase != P_IDLE);
    assign txn_rdata = shreg;
    assign txn_nack  = nack_q;

    always_comb
    begin
        nxt_phase = phase;
        nxt_idx   = idx;
        case (phase)
            P_START: nxt_phase = P_BYTE;
            P_BYTE:  if (bitcnt == 3'd7) nxt_phase = P_ACK;
            P_ACK:
            begin
                if (nack_q || last)
                    nxt_phase = P_STOP;              // stop right after a nack
                else if (rd_q && idx == 2'd1)
                begin
                    nxt_phase = P_START;             // repeated start
                    nxt_idx   = 2'd2;
                end
                else
                begin
                    nxt_phase = P_BYTE;
                    nxt_idx   = idx + 2'd1;
                end
            end
            P_STOP:  nxt_phase = P_IDLE;
            default: nxt_phase = phase;
        endcase
    end

    // --------------------------------------------------
    // phase and line control
    // --------------------------------------------------
    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase       <= P_IDLE;
            qcnt        <= '0;
            q           <= 2'd0;
            bitcnt      <= 3'd0;
            idx         <= 2'd0;
            nack_q      <= 1'b0;
            bus_clk_low <= 1'b0;
            dat_low_m   <= 1'b0;
            txn_end     <= 1'b0;
        end
        else
        begin
            txn_end <= 1'b0;
            if (phase == P_IDLE)
            begin
                if (txn_start)
                begin
                    phase       <= P_START;
                    qcnt        <= '0;
                    q           <= 2'd0;
                    bitcnt      <= 3'd0;
                    idx         <= 2'd0;
                    nack_q      <= 1'b0;
                    bus_clk_low <= 1'b1;
                end
            end
            else if (adv)
            begin
                qcnt <= '0;
                q    <= q + 2'd1;
                case (q)
                    2'd0:   // entering q1, clock low, data may move
                    begin
                        case (phase)
                            P_BYTE:  dat_low_m <= ~shreg[7];
                            P_STOP:  dat_low_m <= 1'b1;
                            default: dat_low_m <= 1'b0;   // start and ack release
                        endcase
                    end
                    2'd1: bus_clk_low <= 1'b0;
                    2'd2:   // rising-edge quarter
                    begin
                        if (phase == P_START)
                            dat_low_m <= 1'b1;           // start edge
                        else if (phase == P_STOP)
                            dat_low_m <= 1'b0;           // stop edge
                        else if (phase == P_ACK && idx != 2'd3)
                            nack_q <= bus_dat;
                    end
                    default:
                    begin
                        phase       <= nxt_phase;
                        idx         <= nxt_idx;
                        bitcnt      <= (phase == P_BYTE) ? bitcnt + 3'd1 : 3'd0;
                        bus_clk_low <= (nxt_phase != P_IDLE);
                        txn_end     <= (phase == P_STOP);
                    end
                endcase
            end
            else if (!stall)
                qcnt <= qcnt + 1'b1;
        end
    end

    // request copy and shift register
    always_ff @(posedge scl)
    begin
        if (phase == P_IDLE && txn_start)
        begin
            rd_q    <= txn_read;
            sel_q   <= txn_sel;
            addr_q  <= txn_addr;
            wdata_q <= txn_wdata;
        end
        if (adv && q == 2'd2 && phase == P_BYTE)
            shreg <= {shreg[6:0], bus_dat};
        if (adv && q == 2'd3 && nxt_phase == P_BYTE && phase != P_BYTE)
            shreg <= byte_for(nxt_idx);
    end

    a_dat_clk_low: assert property (@(posedge scl) disable iff (!rst_n)
        ($changed(dat_low_m) && (phase == P_BYTE || phase == P_ACK)) |-> !bus_clk);

endmodule

`default_nettype wire

// File: hw/eeprom_slave.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_slave (
    input  logic scl,
    input  logic rst_n,
    input  logic bus_clk,
    input  logic bus_dat,
    output logic dat_low_s
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_CTRL, S_ADDR, S_DATA, S_ACK, S_READ} state_t;

    state_t     state;
    state_t     after_ack;    // where to go once the ack bit ends
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_s;
    logic       dat_s;
    logic       clk_d;
    logic       dat_d;
    logic       clk_rise;
    logic       clk_fall;
    logic       start_det;
    logic       stop_det;
    logic [3:0] bitcnt;       // rising edges seen in this byte
    logic [7:0] shreg;
    logic [7:0] tx;
    logic [7:0] addr_q;
    logic       dev_hit;
    logic       mem_we;
    logic [7:0] mem [MEM_DEPTH];

    // --------------------------------------------------
    // line synchronizers and edge detection
    // --------------------------------------------------
    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clk_sync <= 2'b11;    // idle bus floats high
            dat_sync <= 2'b11;
            clk_d    <= 1'b1;
            dat_d    <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[0], bus_clk};
            dat_sync <= {dat_sync[0], bus_dat};
            clk_d    <= clk_s;
            dat_d    <= dat_s;
        end
    end

    assign clk_s     = clk_sync[1];
    assign dat_s     = dat_sync[1];
    assign clk_rise  = clk_s & ~clk_d;
    assign clk_fall  = ~clk_s & clk_d;
    assign start_det = clk_s & clk_d & dat_d & ~dat_s;   // data falls, clock high
    assign stop_det  = clk_s & clk_d & ~dat_d & dat_s;   // data rises, clock high

    assign dev_hit = (shreg[7:1] == {DEV_CODE, DEV_SEL});
    assign mem_we  = (state == S_DATA) && clk_fall && (bitcnt == 4'd8);

    // --------------------------------------------------
    // byte level state machine
    // --------------------------------------------------
    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= S_IDLE;
            after_ack <= S_IDLE;
            bitcnt    <= 4'd0;
            shreg     <= 8'd0;
            tx        <= 8'd0;
            addr_q    <= 8'd0;
            dat_low_s <= 1'b0;
        end
        else if (start_det)
        begin
            state     <= S_CTRL;     // plain or repeated start
            bitcnt    <= 4'd0;
            dat_low_s <= 1'b0;
        end
        else if (stop_det)
        begin
            state     <= S_IDLE;
            bitcnt    <= 4'd0;
            dat_low_s <= 1'b0;
        end
        else if (state != S_IDLE)
        begin
            if (clk_rise)
            begin
                bitcnt <= bitcnt + 4'd1;
                shreg  <= {shreg[6:0], dat_s};
            end
            if (clk_fall)
            begin
                case (state)
                    S_CTRL:
                    begin
                        if (bitcnt == 4'd8 && dev_hit)
                        begin
                            dat_low_s <= 1'b1;
                            state     <= S_ACK;
                            after_ack <= shreg[0] ? S_READ : S_ADDR;
                        end
                        else if (bitcnt == 4'd8)
                            state <= S_IDLE;     // not ours, no ack
                    end
                    S_ADDR:
                    begin
                        if (bitcnt == 4'd8)
                        begin
                            addr_q    <= shreg;
                            dat_low_s <= 1'b1;
                            state     <= S_ACK;
                            after_ack <= S_DATA;
                        end
                    end
                    S_DATA:
                    begin
                        if (bitcnt == 4'd8)
                        begin
                            dat_low_s <= 1'b1;   // byte goes to memory this cycle
                            state     <= S_ACK;
                            after_ack <= S_IDLE;
                        end
                    end
                    S_ACK:
                    begin
                        if (bitcnt == 4'd9)
                        begin
                            bitcnt <= 4'd0;
                            state  <= after_ack;
                            if (after_ack == S_READ)
                            begin
                                tx        <= mem[addr_q];
                                dat_low_s <= ~mem[addr_q][7];   // msb first
                            end
                            else
                                dat_low_s <= 1'b0;
                        end
                    end
                    S_READ:
                    begin
                        if (bitcnt == 4'd8)
                        begin
                            dat_low_s <= 1'b0;   // hand the line over for master nack
                            state     <= S_IDLE;
                        end
                        else
                        begin
                            tx        <= tx << 1;
                            dat_low_s <= ~tx[6];
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // storage, cleared at reset like a blank part
    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < MEM_DEPTH; i++)
                mem[i] <= 8'd0;
        end
        else if (mem_we)
            mem[addr_q] <= shreg;
    end

    a_no_drive_on_rise: assert property (@(posedge scl) disable iff (!rst_n)
        clk_rise |=> $stable(dat_low_s));

endmodule

`default_nettype wire

// File: hw/eeprom_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_subsys_top (
    input  logic       scl,
    input  logic       rst_n,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [1:0] wb_adr,
    input  logic [7:0] wb_dat_w,
    output logic [7:0] wb_dat_r,
    output logic       wb_ack
);

    logic       txn_start;
    logic       txn_read;
    logic [2:0] txn_sel;
    logic [7:0] txn_addr;
    logic [7:0] txn_wdata;
    logic       txn_busy;
    logic       txn_end;
    logic [7:0] txn_rdata;
    logic       txn_nack;
    logic       bus_clk_low;
    logic       dat_low_m;
    logic       dat_low_s;
    logic       bus_clk;
    logic       bus_dat;

    // open-drain lines, high unless someone pulls
    assign bus_clk = ~bus_clk_low;
    assign bus_dat = ~(dat_low_m | dat_low_s);

    wb_eeprom_regs u_regs (
        .scl       (scl),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .txn_busy  (txn_busy),
        .txn_end   (txn_end),
        .txn_rdata (txn_rdata),
        .txn_nack  (txn_nack),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .txn_start (txn_start),
        .txn_read  (txn_read),
        .txn_sel   (txn_sel),
        .txn_addr  (txn_addr),
        .txn_wdata (txn_wdata)
    );

    i2c_txn_master u_master (
        .scl         (scl),
        .rst_n       (rst_n),
        .txn_start   (txn_start),
        .txn_read    (txn_read),
        .txn_sel     (txn_sel),
        .txn_addr    (txn_addr),
        .txn_wdata   (txn_wdata),
        .bus_clk     (bus_clk),
        .bus_dat     (bus_dat),
        .bus_clk_low (bus_clk_low),
        .dat_low_m   (dat_low_m),
        .txn_busy    (txn_busy),
        .txn_end     (txn_end),
        .txn_rdata   (txn_rdata),
        .txn_nack    (txn_nack)
    );

    eeprom_slave u_eeprom (
        .scl       (scl),
        .rst_n     (rst_n),
        .bus_clk   (bus_clk),
        .bus_dat   (bus_dat),
        .dat_low_s (dat_low_s)
    );

endmodule

`default_nettype wire

// File: sim/tb_eeprom_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_subsys;
    import eeprom_pkg::*;

    localparam int CLK_NS       = 40;
    localparam int BIT_CYCLES   = 4 * QUARTER_CYCLES;
    localparam int N_TXN        = 51;                // bus transactions issued below
    localparam int TXN_MAX      = 45 * BIT_CYCLES;
    localparam int WB_PER_TXN   = 24;                // eight accesses of three cycles each
    localparam int LIMIT_CYCLES = 2 * (N_TXN * (TXN_MAX + WB_PER_TXN) + 8);

    logic        scl;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [7:0]  wb_dat_w;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;

    logic        chk_en;                             // arms the read value check
    logic [7:0]  chk_val;
    logic [7:0]  chk_mask;
    string       chk_name;
    int          n_checks;
    int          n_errors;
    logic [31:0] rnd;
    logic [7:0]  ref_mem [MEM_DEPTH];                // expected eeprom contents
    logic [7:0]  written [20];

    eeprom_subsys_top uut (
        .scl      (scl),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial
    begin
        scl = 1'b0;
        forever #(CLK_NS / 2) scl = ~scl;
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_read_value: assert property (@(posedge scl) disable iff (!rst_n)
        (chk_en && wb_ack) |-> ((wb_dat_r & chk_mask) == chk_val))
        else
        begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s read 0x%02h, expected 0x%02h",
                     $time, chk_name, $sampled(wb_dat_r) & chk_mask, chk_val);
        end

    a_ack_after_stb: assert property (@(posedge scl) disable iff (!rst_n)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else
        begin
            n_errors++;
            $display("CHECK FAILED at %0t: wb_ack missing one cycle after strobe", $time);
        end

    a_ack_one_cycle: assert property (@(posedge scl) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else
        begin
            n_errors++;
            $display("CHECK FAILED at %0t: wb_ack held longer than one cycle", $time);
        end

    a_end_with_busy_fall: assert property (@(posedge scl) disable iff (!rst_n)
        $fell(uut.txn_busy) |-> uut.txn_end)
        else
        begin
            n_errors++;
            $display("CHECK FAILED at %0t: busy fell without txn_end", $time);
        end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] make_cmd(input logic rd, input logic [2:0] sel);
        logic [7:0] c;
        c = 8'd0;
        c[CMD_GO_BIT]         = 1'b1;
        c[CMD_READ_BIT]       = rd;
        c[CMD_SEL_LSB +: 3]   = sel;
        return c;
    endfunction

    function automatic logic [7:0] done_status(input logic nack);
        logic [7:0] s;
        s = 8'd0;
        s[ST_DONE_BIT] = 1'b1;
        s[ST_NACK_BIT] = nack;
        return s;
    endfunction

    // --------------------------------------------------
    // wishbone host tasks
    // --------------------------------------------------
    task automatic wb_write(input logic [1:0] adr, input logic [7:0] dat);
        @(negedge scl);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(negedge scl);
        while (!wb_ack)
            @(negedge scl);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [7:0] dat);
        @(negedge scl);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(negedge scl);
        while (!wb_ack)
            @(negedge scl);
        dat    = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic expect_read(input logic [1:0] adr, input logic [7:0] val,
                               input logic [7:0] mask, input string name);
        logic [7:0] got;
        while (wb_ack)
            @(negedge scl);                          // ack of the previous access
        chk_val  = val & mask;
        chk_mask = mask;
        chk_name = name;
        chk_en   = 1'b1;
        n_checks++;
        wb_read(adr, got);
        @(negedge scl);                              // ack edge has been checked
        chk_en = 1'b0;
    endtask

    task automatic wait_idle();
        logic [7:0] st;
        wb_read(REG_STATUS, st);
        while (st[ST_BUSY_BIT])
            wb_read(REG_STATUS, st);
    endtask

    task automatic run_txn(input logic rd, input logic [2:0] sel,
                           input logic [7:0] addr, input logic [7:0] dat);
        wb_write(REG_ADDR, addr);
        if (!rd)
            wb_write(REG_DATA, dat);
        wb_write(REG_CMD, make_cmd(rd, sel));
        wait_idle();
        if (!rd && sel == DEV_SEL)
            ref_mem[addr] = dat;                     // only an acknowledged write lands
    endtask

    task automatic check_txn(input logic rd, input logic [7:0] addr, input logic nack);
        expect_read(REG_STATUS, done_status(nack), 8'hff, "status");
        if (rd && !nack)
            expect_read(REG_DATA, ref_mem[addr], 8'hff, "read data");
    endtask

    initial
    begin
        #(LIMIT_CYCLES * CLK_NS);
        $display("watchdog expired at %0t, transactions did not complete in time", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial
    begin
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] busy_st;
        logic [2:0] bad_sel;
        int         pick;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 2'd0;
        wb_dat_w = 8'd0;
        chk_en   = 1'b0;
        chk_val  = 8'd0;
        chk_mask = 8'd0;
        chk_name = "";
        n_checks = 0;
        n_errors = 0;
        rnd      = 32'hb7ae_619d;
        for (int i = 0; i < MEM_DEPTH; i++)
            ref_mem[i] = 8'd0;
        repeat (3) @(posedge scl);
        @(negedge scl);
        rst_n = 1'b1;

        // blank part after reset
        expect_read(REG_STATUS, 8'h00, 8'hff, "status after reset");
        rnd = lcg_next(rnd);
        a = rnd[7:0];
        run_txn(1'b1, DEV_SEL, a, 8'h00);
        check_txn(1'b1, a, 1'b0);

        // random writes with a read back of some earlier address
        for (int i = 0; i < 20; i++)
        begin
            rnd = lcg_next(rnd);
            a = rnd[7:0];
            run_txn(1'b0, DEV_SEL, a, rnd[15:8]);
            check_txn(1'b0, a, 1'b0);
            written[i] = a;
            pick = int'(rnd[31:16]) % (i + 1);
            b = written[pick];
            run_txn(1'b1, DEV_SEL, b, 8'h00);
            check_txn(1'b1, b, 1'b0);
        end

        // wrong device select gets no ack
        bad_sel = DEV_SEL + 3'd1;
        a = written[0];
        run_txn(1'b0, bad_sel, a, ~ref_mem[a]);
        check_txn(1'b0, a, 1'b1);
        run_txn(1'b1, bad_sel, a, 8'h00);
        check_txn(1'b1, a, 1'b1);
        run_txn(1'b1, DEV_SEL, a, 8'h00);
        check_txn(1'b1, a, 1'b0);

        // second command while busy is dropped
        rnd = lcg_next(rnd);
        a = rnd[7:0];
        b = a ^ 8'h80;
        run_txn(1'b0, DEV_SEL, a, 8'h5a);
        run_txn(1'b0, DEV_SEL, b, 8'ha5);
        busy_st = 8'd0;
        busy_st[ST_BUSY_BIT] = 1'b1;
        wb_write(REG_ADDR, a);
        wb_write(REG_CMD, make_cmd(1'b1, DEV_SEL));
        expect_read(REG_STATUS, busy_st, busy_st, "busy during read");
        wb_write(REG_ADDR, b);
        wb_write(REG_CMD, make_cmd(1'b1, DEV_SEL));
        wait_idle();
        check_txn(1'b1, a, 1'b0);

        // overwrite keeps last value and leaves the neighbour alone
        rnd = lcg_next(rnd);
        a = rnd[7:0];
        run_txn(1'b0, DEV_SEL, a, rnd[15:8]);
        run_txn(1'b0, DEV_SEL, a, ~rnd[15:8]);
        run_txn(1'b1, DEV_SEL, a, 8'h00);
        check_txn(1'b1, a, 1'b0);
        run_txn(1'b1, DEV_SEL, a + 8'd1, 8'h00);
        check_txn(1'b1, a + 8'd1, 1'b0);

        repeat (4) @(posedge scl);
        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/eeprom_pkg.sv
hw/wb_eeprom_regs.sv
hw/i2c_txn_master.sv
hw/eeprom_slave.sv
hw/eeprom_subsys_top.sv
sim/tb_eeprom_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the eeprom subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_eeprom_subsys -f vlog.f > sim.log 2>&1 \
    && ./obj_dir/Vtb_eeprom_subsys >> sim.log 2>&1 \
    || echo "TESTBENCH FAILED" >> sim.log

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
exit 0
